// File: design/prefetch_pkg.sv
package prefetch_pkg;

    // --------------------
    // Address and request sizes
    // --------------------
    localparam int addr_w      = 32;   // Linear address width
    localparam int len_w       = 5;    // Request length, 0 to 16 bytes
    localparam int max_req_len = 16;   // Largest single request toward the engine
    localparam int cnt_w       = 3;    // Bytes held by one FIFO entry, 0 to 4

    // --------------------
    // Startup state
    // --------------------
    // Execution starts 16 bytes below the top of the address space
    localparam logic [addr_w-1:0] startup_linear = 32'hFFFF_FFF0;
    localparam logic [addr_w-1:0] startup_limit  = 32'd16;   // Enough for the reset vector

    // Granularity bit of a code-segment descriptor
    localparam int desc_bit_g = 55;

    // --------------------
    // Prefetch FIFO
    // --------------------
    localparam int fifo_depth = 8;
    localparam int fifo_cnt_w = 4;     // Counts 0 to fifo_depth free slots

    // Engine FSM encodings
    localparam logic [1:0] st_idle = 2'd0;   // No bus cycle open
    localparam logic [1:0] st_bus  = 2'd1;   // Cycle open, data will be kept
    localparam logic [1:0] st_drop = 2'd2;   // Cycle open, data is stale after a pr_reset

endpackage

// File: design/prefetch_req_if.sv
`timescale 1ns/1ps

// Request from the address tracker to the bus engine, and its completion back
interface prefetch_req_if;

    logic [prefetch_pkg::addr_w-1:0] address;     // Next linear byte to fetch
    logic [prefetch_pkg::len_w-1:0]  length;      // Bytes wanted, zero means no request
    logic                            su;          // User mode access
    logic                            limit_do;    // Segment limit hit, marker is due

    logic                            done;        // One-cycle completion pulse
    logic [prefetch_pkg::len_w-1:0]  done_length; // Bytes consumed from address

    // The tracker owns the request
    modport tracker (
        output address, length, su, limit_do,
        input  done, done_length
    );

    // The engine owns the completion
    modport engine (
        input  address, length, su, limit_do,
        output done, done_length
    );

endinterface

// File: design/prefetch.sv
`timescale 1ns/1ps

module prefetch (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pr_reset,    // Reload from cs and eip
    input  logic [1:0]                      cpl,         // Current privilege level
    input  logic [prefetch_pkg::addr_w-1:0] eip,
    input  logic [63:0]                     cs_cache,    // Code-segment descriptor
    prefetch_req_if.tracker                 req
);

    // --------------------
    // State
    // --------------------
    logic [prefetch_pkg::addr_w-1:0] linear;      // Next linear fetch address
    logic [prefetch_pkg::addr_w-1:0] limit;       // Bytes left before the segment end
    logic                            signaled;    // Marker already handed to the engine

    logic [prefetch_pkg::addr_w-1:0] cs_base;
    logic [prefetch_pkg::addr_w-1:0] cs_limit;
    logic [prefetch_pkg::len_w-1:0]  consumed;    // Completion capped at the limit

    // --------------------
    // Descriptor decode
    // --------------------
    assign cs_base = {cs_cache[63:56], cs_cache[39:16]};   // Base is split in two fields

    // With G set the 20-bit limit counts 4 KiB pages, low 12 bits all ones
    assign cs_limit = cs_cache[prefetch_pkg::desc_bit_g] ?
                      {cs_cache[51:48], cs_cache[15:0], 12'hFFF} :
                      {12'd0, cs_cache[51:48], cs_cache[15:0]};

    // --------------------
    // Request toward the engine
    // --------------------
    assign req.address = linear;
    assign req.su      = (cpl == 2'd3);   // Ring 3 is the only user level

    // Never ask for more than one 16-byte block at a time
    assign req.length = (limit > prefetch_pkg::max_req_len) ?
                        prefetch_pkg::len_w'(prefetch_pkg::max_req_len) :
                        limit[prefetch_pkg::len_w-1:0];

    // The engine may report more than is left inside the segment
    assign consumed = (limit < prefetch_pkg::addr_w'(req.done_length)) ?
                      limit[prefetch_pkg::len_w-1:0] : req.done_length;

    // Held until the engine has taken the marker once
    assign req.limit_do = (limit == '0) && !signaled;

    // --------------------
    // Registers
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            linear <= prefetch_pkg::startup_linear;
            limit  <= prefetch_pkg::startup_limit;
        end else if (pr_reset) begin
            linear <= cs_base + eip;
            // An eip past the limit leaves nothing to fetch
            limit  <= (cs_limit >= eip) ? cs_limit - eip + 1'b1 : '0;
        end else if (req.done) begin
            linear <= linear + prefetch_pkg::addr_w'(consumed);
            limit  <= limit - prefetch_pkg::addr_w'(consumed);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            signaled <= 1'b0;
        end else if (pr_reset) begin
            signaled <= 1'b0;   // A new segment may need its own marker
        end else if (req.limit_do) begin
            signaled <= 1'b1;   // The engine pushes the marker on this same cycle
        end
    end

endmodule

// File: design/fetch_wb.sv
`timescale 1ns/1ps

module fetch_wb (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                pr_reset,
    prefetch_req_if.engine                      req,
    // Wishbone classic read master
    output logic                                wb_cyc,
    output logic                                wb_stb,
    output logic                                wb_we,
    output logic                                wb_tga,
    output logic [prefetch_pkg::addr_w-1:0]     wb_adr,
    output logic [3:0]                          wb_sel,
    input  logic [31:0]                         wb_dat_r,
    input  logic                                wb_ack,
    // FIFO write side
    output logic                                push,
    output logic                                push_limit,
    output logic [31:0]                         push_data,
    output logic [prefetch_pkg::cnt_w-1:0]      push_count,
    input  logic [prefetch_pkg::fifo_cnt_w-1:0] free_entries
);

    logic [1:0]                        state;
    logic [prefetch_pkg::addr_w-3:0]   adr_q;      // Dword address of the open cycle
    logic [1:0]                        offset_q;   // First wanted byte inside the dword
    logic [prefetch_pkg::cnt_w-1:0]    count_q;    // Bytes the open cycle delivers

    logic [prefetch_pkg::cnt_w-1:0]    avail;      // Bytes from offset to dword end
    logic [prefetch_pkg::cnt_w-1:0]    count;
    logic                              start;
    logic                              data_push;
    logic                              marker;

    // --------------------
    // Cycle start
    // --------------------
    assign avail = prefetch_pkg::cnt_w'(4) - prefetch_pkg::cnt_w'(req.address[1:0]);

    // Short requests at the segment end take fewer bytes than the dword holds
    assign count = (req.length < prefetch_pkg::len_w'(avail)) ?
                   req.length[prefetch_pkg::cnt_w-1:0] : avail;

    // Two free slots so a marker always fits behind the data entry
    assign start = (state == prefetch_pkg::st_idle) && (req.length != '0) &&
                   (free_entries >= prefetch_pkg::fifo_cnt_w'(2)) && !pr_reset;

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= prefetch_pkg::st_idle;
        end else begin
            case (state)
                prefetch_pkg::st_idle: if (start) state <= prefetch_pkg::st_bus;
                prefetch_pkg::st_bus: begin
                    if (wb_ack) begin
                        state <= prefetch_pkg::st_idle;   // Drops cyc for one cycle
                    end else if (pr_reset) begin
                        state <= prefetch_pkg::st_drop;   // Finish the cycle, keep nothing
                    end
                end
                prefetch_pkg::st_drop: if (wb_ack) state <= prefetch_pkg::st_idle;
                default: state <= prefetch_pkg::st_idle;
            endcase
        end
    end

    // Address and byte count are held for the whole bus cycle
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q    <= req.address[prefetch_pkg::addr_w-1:2];
            offset_q <= req.address[1:0];
            count_q  <= count;
        end
    end

    // --------------------
    // Bus outputs
    // --------------------
    assign wb_cyc = (state != prefetch_pkg::st_idle);
    assign wb_stb = wb_cyc;                 // Single reads, stb follows cyc
    assign wb_we  = 1'b0;
    assign wb_sel = 4'hF;                   // Whole dword is always read
    assign wb_tga = req.su;
    assign wb_adr = {adr_q, 2'b00};

    // --------------------
    // Completion and FIFO push
    // --------------------
    // A pr_reset on the ack cycle discards the data as well
    assign data_push = (state == prefetch_pkg::st_bus) && wb_ack && !pr_reset;

    // Limit marker goes first, it never meets a data push because limit is zero
    assign marker = req.limit_do && !pr_reset;

    assign req.done        = data_push;
    assign req.done_length = prefetch_pkg::len_w'(count_q);

    assign push       = data_push || marker;
    assign push_limit = marker;
    assign push_count = marker ? '0 : count_q;
    assign push_data  = marker ? '0 : (wb_dat_r >> {offset_q, 3'b000});   // Byte 0 first

endmodule

// File: design/prefetch_fifo.sv
`timescale 1ns/1ps

module prefetch_fifo (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,        // Drops every entry at once
    input  logic                                push,
    input  logic                                push_limit,
    input  logic [31:0]                         push_data,
    input  logic [prefetch_pkg::cnt_w-1:0]      push_count,
    output logic [prefetch_pkg::fifo_cnt_w-1:0] free_entries,
    output logic                                code_valid,
    input  logic                                code_ready,
    output logic [31:0]                         code_data,
    output logic [prefetch_pkg::cnt_w-1:0]      code_count,
    output logic                                code_limit
);

    // --------------------
    // Storage
    // --------------------
    logic [31:0]                          mem_data  [prefetch_pkg::fifo_depth];
    logic [prefetch_pkg::cnt_w-1:0]       mem_count [prefetch_pkg::fifo_depth];
    logic                                 mem_limit [prefetch_pkg::fifo_depth];

    logic [$clog2(prefetch_pkg::fifo_depth)-1:0] wr_ptr;   // Wraps naturally at the depth
    logic [$clog2(prefetch_pkg::fifo_depth)-1:0] rd_ptr;
    logic [prefetch_pkg::fifo_cnt_w-1:0]         used;     // Entries held

    logic do_push;
    logic do_pop;

    assign do_pop  = code_valid && code_ready;
    assign do_push = push && ((free_entries != '0) || do_pop);   // A full FIFO ignores push

    // Entry data sits in registers, so it shows one cycle after the write
    assign code_valid   = (used != '0);
    assign code_data    = mem_data[rd_ptr];
    assign code_count   = mem_count[rd_ptr];
    assign code_limit   = mem_limit[rd_ptr];
    assign free_entries = prefetch_pkg::fifo_cnt_w'(prefetch_pkg::fifo_depth) - used;

    // --------------------
    // Pointers and fill level
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            // Push and pop together leave the level unchanged
            if (do_push && !do_pop) begin
                used <= used + 1'b1;
            end else if (do_pop && !do_push) begin
                used <= used - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            mem_data[wr_ptr]  <= push_data;
            mem_count[wr_ptr] <= push_count;
            mem_limit[wr_ptr] <= push_limit;
        end
    end

endmodule

// File: design/prefetch_top.sv
`timescale 1ns/1ps

module prefetch_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pr_reset,
    input  logic [1:0]                      cpl,
    input  logic [prefetch_pkg::addr_w-1:0] eip,
    input  logic [63:0]                     cs_cache,
    // Wishbone classic, read only
    output logic                            wb_cyc,
    output logic                            wb_stb,
    output logic                            wb_we,
    output logic                            wb_tga,
    output logic [prefetch_pkg::addr_w-1:0] wb_adr,
    output logic [3:0]                      wb_sel,
    input  logic [31:0]                     wb_dat_r,
    input  logic                            wb_ack,
    // Decoder side
    output logic                            code_valid,
    input  logic                            code_ready,
    output logic [31:0]                     code_data,
    output logic [prefetch_pkg::cnt_w-1:0]  code_count,
    output logic                            code_limit
);

    // --------------------
    // Internal wiring
    // --------------------
    prefetch_req_if req_if ();

    logic                                push;
    logic                                push_limit;
    logic [31:0]                         push_data;
    logic [prefetch_pkg::cnt_w-1:0]      push_count;
    logic [prefetch_pkg::fifo_cnt_w-1:0] free_entries;

    // Address and limit tracker
    prefetch prefetch_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pr_reset (pr_reset),
        .cpl      (cpl),
        .eip      (eip),
        .cs_cache (cs_cache),
        .req      (req_if.tracker)
    );

    // Bus engine
    fetch_wb fetch_wb_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pr_reset     (pr_reset),
        .req          (req_if.engine),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_tga       (wb_tga),
        .wb_adr       (wb_adr),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .push         (push),
        .push_limit   (push_limit),
        .push_data    (push_data),
        .push_count   (push_count),
        .free_entries (free_entries)
    );

    // pr_reset also empties the prefetch FIFO
    prefetch_fifo prefetch_fifo_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (pr_reset),
        .push         (push),
        .push_limit   (push_limit),
        .push_data    (push_data),
        .push_count   (push_count),
        .free_entries (free_entries),
        .code_valid   (code_valid),
        .code_ready   (code_ready),
        .code_data    (code_data),
        .code_count   (code_count),
        .code_limit   (code_limit)
    );

endmodule

// File: sim/tb_wb_mem.sv
`timescale 1ns/1ps

// Wishbone classic read-only memory with a random number of wait states
module tb_wb_mem #(
    parameter int seed_init = 1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic [31:0] wb_adr,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    int          seed = seed_init;
    logic [31:0] delay_rnd;
    logic [1:0]  wait_cnt;   // Wait states left before the ack

    // Every address bit reaches the byte value
    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= 32'd0;
            wait_cnt <= 2'd0;
        end else if (wb_ack) begin
            wb_ack    <= 1'b0;                 // Master drops cyc after the ack
            delay_rnd = $random(seed);
            wait_cnt  <= delay_rnd[1:0];       // Next cycle gets 0 to 3 extra waits
        end else if (wb_cyc && wb_stb) begin
            if (wait_cnt == 2'd0) begin
                wb_ack   <= 1'b1;
                // Little endian, lowest address in the low byte
                wb_dat_r <= {mem_byte(wb_adr + 32'd3), mem_byte(wb_adr + 32'd2),
                             mem_byte(wb_adr + 32'd1), mem_byte(wb_adr)};
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

// File: sim/tb_prefetch.sv
`timescale 1ns/1ps

module tb_prefetch;

    // --------------------
    // Test constants
    // --------------------
    localparam int rand_seed  = 32'h1939_fc87;
    localparam int clk_period = 4;
    localparam int quiet_cyc  = 20;   // Cycles watched for stray entries after a marker
    // Reset vector, byte-granular segment, G window, both streams of the restart test
    localparam int total_bytes = 16 + 47 + 48 + 20 + 30;
    localparam int timeout_cyc = 200 * total_bytes + 2000;

    logic        clk;
    logic        rst_n;
    logic        pr_reset;
    logic [1:0]  cpl;
    logic [31:0] eip;
    logic [63:0] cs_cache;
    logic        code_ready = 1'b0;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_tga;
    logic [31:0] wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        code_valid;
    logic [31:0] code_data;
    logic [2:0]  code_count;
    logic        code_limit;

    // Reference model of the current stream
    logic [7:0]  exp_q[$];            // Bytes the consumer still has to see
    logic        marker_exp;          // Stream ends in a limit marker
    logic        marker_seen;
    logic        open_stream;         // Only a window of an endless stream is checked
    logic        cyc_prev = 1'b0;
    int          cyc_starts = 0;      // Bus cycles opened since the last restart
    int          errors = 0;
    int          bytes_checked = 0;
    int          seed = rand_seed;
    logic [31:0] ready_rnd;
    logic        hold_ready = 1'b0;   // Consumer stalled so the FIFO fills up

    prefetch_top dut_i (.*);

    tb_wb_mem #(.seed_init(rand_seed)) mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
    endfunction

    // x86 code-segment descriptor, the base and the limit are split over the two dwords
    function automatic logic [63:0] code_desc(input logic [31:0] base, input logic [19:0] lim,
                                              input logic g);
        logic [63:0] d;
        d        = 64'd0;
        d[15:0]  = lim[15:0];
        d[39:16] = base[23:0];
        d[47:40] = 8'h9A;      // Present, ring 0, readable code
        d[51:48] = lim[19:16];
        d[55]    = g;
        d[63:56] = base[31:24];
        return d;
    endfunction

    task automatic expect_stream(input logic [31:0] first, input int nbytes, input logic marker);
        exp_q.delete();
        for (int i = 0; i < nbytes; i++) begin
            exp_q.push_back(mem_byte(first + 32'(i)));
        end
        marker_exp  = marker;
        marker_seen = 1'b0;
        open_stream = !marker;   // No marker means the segment outlasts the window
        cyc_starts  = 0;
    endtask

    // Called right after a rising edge, pr_reset is high for one cycle
    task automatic restart(input logic [31:0] base, input logic [31:0] eip_v,
                           input logic [19:0] lim, input logic g, input logic [1:0] cpl_v,
                           input int window);
        logic [31:0] seg_end;
        longint      total;
        seg_end  = g ? {lim, 12'hFFF} : {12'd0, lim};   // Last valid offset in the segment
        total    = (eip_v > seg_end) ? 64'd0 : longint'(seg_end) - longint'(eip_v) + 64'd1;
        cs_cache <= code_desc(base, lim, g);
        eip      <= eip_v;
        cpl      <= cpl_v;
        pr_reset <= 1'b1;
        @(posedge clk);
        pr_reset <= 1'b0;
        // Entries popped on the flush edge are skipped by the checker
        if (total > longint'(window)) begin
            expect_stream(base + eip_v, window, 1'b0);
        end else begin
            expect_stream(base + eip_v, int'(total), 1'b1);
        end
    endtask

    task automatic wait_stream();
        while (exp_q.size() != 0 || (marker_exp && !marker_seen)) @(posedge clk);
        if (marker_exp) repeat (quiet_cyc) @(posedge clk);   // Nothing may follow the marker
    endtask

    // --------------------
    // Consumer side checker
    // --------------------
    always @(posedge clk) begin : stream_check
        logic [7:0] got;
        logic [7:0] want;
        if (!rst_n) begin
            assert (!wb_cyc && !wb_stb && !code_valid) else begin
                errors++;
                $display("Bus or consumer port active while in reset");
            end
        end else if (code_valid && code_ready && !pr_reset) begin
            if (code_limit) begin
                assert (marker_exp && !marker_seen && exp_q.size() == 0) else begin
                    errors++;
                    $display("Limit marker arrived where none was due");
                end
                assert (code_count == 3'd0) else begin
                    errors++;
                    $display("[ERROR] code_count on marker: got %h expected %h", code_count, 3'd0);
                end
                marker_seen = 1'b1;
            end else begin
                for (int i = 0; i < int'(code_count); i++) begin
                    if (exp_q.size() != 0) begin
                        want = exp_q.pop_front();
                        got  = 8'(code_data >> (8 * i));
                        assert (got == want) else begin
                            errors++;
                            $display("[ERROR] code_data byte %0d: got %h expected %h", i, got, want);
                        end
                        bytes_checked++;
                    end else begin
                        assert (open_stream) else begin
                            errors++;
                            $display("Data byte arrived after the end of the stream");
                        end
                    end
                end
            end
        end
    end

    // Bus rules on every strobe cycle
    always @(posedge clk) begin
        if (rst_n && wb_stb) begin
            assert (wb_tga == (cpl == 2'd3)) else begin
                errors++;
                $display("[ERROR] wb_tga: got %h expected %h", wb_tga, cpl == 2'd3);
            end
            assert (!wb_we) else begin
                errors++;
                $display("[ERROR] wb_we: got %h expected %h", wb_we, 1'b0);
            end
            assert (wb_sel == 4'hF) else begin
                errors++;
                $display("[ERROR] wb_sel: got %h expected %h", wb_sel, 4'hF);
            end
            assert (wb_adr[1:0] == 2'b00) else begin
                errors++;
                $display("[ERROR] wb_adr: got %h expected dword aligned", wb_adr);
            end
        end
        if (wb_cyc && !cyc_prev) cyc_starts++;
        cyc_prev = wb_cyc;
    end

    always @(posedge clk) begin
        ready_rnd = $random(seed);
        // Ready about three cycles in four unless the consumer is stalled
        code_ready <= !hold_ready && (ready_rnd[1] | ready_rnd[0]);
    end

    initial begin
        #(timeout_cyc * clk_period);
        $display("Watchdog timeout, the stream did not finish within %0d cycles", timeout_cyc);
        $display("Checked %0d bytes, %0d errors", bytes_checked, errors);
        $display("STATUS: FAIL");
        $finish;
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        rst_n    <= 1'b0;
        pr_reset <= 1'b0;
        cpl      <= 2'd0;
        eip      <= 32'd0;
        cs_cache <= 64'd0;
        expect_stream(32'hFFFF_FFF0, 16, 1'b1);   // Reset vector up to the startup limit
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait_stream();

        // Byte-granular segment with an unaligned start, 47 bytes then a marker
        restart(32'h0001_2000, 32'h0000_0103, 20'h00131, 1'b0, 2'd0, 1000);
        // Stalled consumer, the FIFO fills and the engine has to stop
        hold_ready <= 1'b1;
        repeat (64) @(posedge clk);
        assert (!wb_cyc) else begin
            errors++;
            $display("A bus cycle is open although the FIFO has no room left");
        end
        hold_ready <= 1'b0;
        wait_stream();

        // eip past the limit
        restart(32'h0003_0000, 32'h0000_0200, 20'h001FF, 1'b0, 2'd0, 1000);
        wait_stream();
        assert (cyc_starts == 0) else begin
            errors++;
            $display("A bus cycle started although eip lies past the limit");
        end

        restart(32'h0040_0000, 32'h0000_1F00, 20'h00001, 1'b1, 2'd1, 48);   // G gives 0x1FFF
        wait_stream();

        // User-mode stream cut by pr_reset while a bus cycle is open
        restart(32'h0800_0000, 32'h0000_0011, 20'h0FFFF, 1'b0, 2'd3, 20);
        wait_stream();
        while (!(wb_cyc && !wb_ack)) @(posedge clk);
        restart(32'h0010_0000, 32'h0000_0A02, 20'h00A1F, 1'b0, 2'd3, 1000);
        wait_stream();

        $display("Checked %0d bytes, %0d errors", bytes_checked, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
design/prefetch_pkg.sv
design/prefetch_req_if.sv
design/prefetch.sv
design/fetch_wb.sv
design/prefetch_fifo.sv
design/prefetch_top.sv
sim/tb_wb_mem.sv
sim/tb_prefetch.sv

// File: run.sh
#!/bin/sh
# Build and run the prefetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_prefetch -o tb_prefetch

out=$(./obj_dir/tb_prefetch)
echo "$out"
echo "$out" | grep -q "STATUS: PASS"
